//--- verilog/aud_pkg.sv
package aud_pkg;

    // I2S frame layout
    localparam int NUM_CH      = 2;
    localparam int SAMPLE_BITS = 16;
    localparam int SLOT_DELAY  = 1;  // Bit-clocks between lrc edge and MSB

    // Sample memory
    localparam int ADDR_BITS = 20;
    localparam int MEM_DEPTH = 1024000;

    // Derived widths
    localparam int SLOT_LAST = SLOT_DELAY + SAMPLE_BITS - 1;  // Count at last sampled bit
    localparam int CNT_W     = $clog2(SLOT_LAST + 1);
    localparam int CH_W      = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

    typedef logic [SAMPLE_BITS-1:0] sample_t;
    typedef logic [ADDR_BITS-1:0]   addr_t;
    typedef logic [CH_W-1:0]        ch_t;

    typedef enum logic [2:0] {
        IDLE,
        ARM,     // Waiting for a left slot boundary
        REC,
        PAUSE,
        FINISH
    } xport_state_t;

endpackage

//--- verilog/aud_transport.sv
`timescale 1ns/10ps

module aud_transport (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_pause,
    input  logic i_stop,
    input  logic i_lrc,
    input  logic i_full,
    output logic o_rec_en,
    output logic o_clear,
    output logic o_recording,
    output logic o_finish
);
    import aud_pkg::*;

    xport_state_t state_r;
    xport_state_t state_w;
    logic         lrc_d;
    logic         lrc_fall;

    assign lrc_fall = lrc_d & ~i_lrc;  // Start of a left slot

    always_comb begin
        state_w = state_r;
        case (state_r)
            IDLE: begin
                if (i_start) begin
                    state_w = ARM;
                end
            end
            ARM: begin
                if (lrc_fall) begin
                    state_w = REC;
                end
            end
            REC: begin
                // Stop outranks a pause in the same cycle
                if (i_stop || i_full) begin
                    state_w = FINISH;
                end else if (i_pause) begin
                    state_w = PAUSE;
                end
            end
            PAUSE: begin
                if (i_stop) begin
                    state_w = FINISH;
                end else if (i_pause) begin
                    state_w = REC;
                end
            end
            FINISH: begin
                state_w = IDLE;
            end
            default: begin
                state_w = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r <= IDLE;
            lrc_d   <= 1'b0;
        end else begin
            state_r <= state_w;
            lrc_d   <= i_lrc;
        end
    end

    // Enable rises on the boundary edge itself so the left slot latches it
    assign o_rec_en    = (state_r == REC) | ((state_r == ARM) & lrc_fall);
    assign o_clear     = (state_r == IDLE) & i_start;  // Address back to 0
    assign o_recording = (state_r == REC);
    assign o_finish    = (state_r == FINISH);

endmodule

//--- verilog/aud_slot_deser.sv
`timescale 1ns/10ps

module aud_slot_deser #(
    parameter int unsigned CH_LEVEL = 0
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_lrc,
    input  logic             i_data,
    input  logic             i_rec_en,
    output aud_pkg::sample_t o_sample,
    output logic             o_sample_vld
);
    import aud_pkg::*;

    logic             lrc_d;
    logic             slot_start;
    logic             active;    // Slot being captured
    logic             shift_en;
    logic [CNT_W-1:0] bit_cnt;   // Edges since slot start
    sample_t          sample_r;

    // First edge that sees lrc move into this channel's level
    assign slot_start = (i_lrc != lrc_d) && (i_lrc == 1'(CH_LEVEL));

    // The slot start edge itself is the delay bit
    assign shift_en = active && (bit_cnt >= CNT_W'(SLOT_DELAY));

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            lrc_d        <= 1'b0;
            active       <= 1'b0;
            bit_cnt      <= '0;
            o_sample_vld <= 1'b0;
        end else begin
            lrc_d        <= i_lrc;
            o_sample_vld <= 1'b0;
            if (slot_start) begin
                active  <= i_rec_en;  // Latched once per slot
                bit_cnt <= CNT_W'(1);
            end else if (active) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == CNT_W'(SLOT_LAST)) begin
                    active       <= 1'b0;
                    o_sample_vld <= 1'b1;
                end
            end
        end
    end

    // MSB first
    always_ff @(posedge i_clk) begin
        if (shift_en) begin
            sample_r <= {sample_r[SAMPLE_BITS-2:0], i_data};
        end
    end

    assign o_sample = sample_r;

endmodule

//--- verilog/aud_mem_writer.sv
`timescale 1ns/10ps

module aud_mem_writer (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_clear,
    input  logic [aud_pkg::NUM_CH-1:0]             i_sample_vld,
    input  aud_pkg::sample_t [aud_pkg::NUM_CH-1:0] i_sample,
    output aud_pkg::addr_t                         o_address,
    output aud_pkg::sample_t                       o_data,
    output logic                                   o_wr,
    output logic                                   o_full
);
    import aud_pkg::*;

    ch_t     sel;
    logic    any_vld;
    addr_t   addr_r;
    sample_t data_r;
    logic    wr_r;
    logic    full_r;

    // Slots never overlap, so at most one valid is set
    always_comb begin
        sel     = '0;
        any_vld = 1'b0;
        for (int k = 0; k < NUM_CH; k++) begin
            if (i_sample_vld[k]) begin
                sel     = ch_t'(k);
                any_vld = 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            wr_r   <= 1'b0;
            addr_r <= '0;
            full_r <= 1'b0;
        end else begin
            wr_r <= any_vld & ~full_r;  // Drop samples once full
            if (i_clear) begin
                addr_r <= '0;
                full_r <= 1'b0;
            end else if (wr_r) begin
                // Advance after the write cycle
                if (addr_r == addr_t'(MEM_DEPTH - 1)) begin
                    full_r <= 1'b1;
                end else begin
                    addr_r <= addr_r + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (any_vld) begin
            data_r <= i_sample[sel];
        end
    end

    assign o_address = addr_r;
    assign o_data    = data_r;
    assign o_wr      = wr_r;
    assign o_full    = full_r;

endmodule

//--- verilog/aud_recorder_top.sv
`timescale 1ns/10ps

module aud_recorder_top (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_lrc,
    input  logic             i_data,
    input  logic             i_start,
    input  logic             i_pause,
    input  logic             i_stop,
    output aud_pkg::addr_t   o_address,
    output aud_pkg::sample_t o_data,
    output logic             o_wr,
    output logic             o_recording,
    output logic             o_finish
);
    import aud_pkg::*;

    logic                     rec_en;
    logic                     clear;
    logic                     full;
    logic [NUM_CH-1:0]        sample_vld;
    sample_t [NUM_CH-1:0]     sample;

    aud_transport i_aud_transport (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_pause     (i_pause),
        .i_stop      (i_stop),
        .i_lrc       (i_lrc),
        .i_full      (full),
        .o_rec_en    (rec_en),
        .o_clear     (clear),
        .o_recording (o_recording),
        .o_finish    (o_finish)
    );

    // Channel 0 is left (lrc low), channel 1 right (lrc high)
    for (genvar k = 0; k < NUM_CH; k++) begin : g_deser
        aud_slot_deser #(
            .CH_LEVEL (k)
        ) i_aud_slot_deser (
            .i_clk        (i_clk),
            .i_rst_n      (i_rst_n),
            .i_lrc        (i_lrc),
            .i_data       (i_data),
            .i_rec_en     (rec_en),
            .o_sample     (sample[k]),
            .o_sample_vld (sample_vld[k])
        );
    end

    aud_mem_writer i_aud_mem_writer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_clear      (clear),
        .i_sample_vld (sample_vld),
        .i_sample     (sample),
        .o_address    (o_address),
        .o_data       (o_data),
        .o_wr         (o_wr),
        .o_full       (full)
    );

endmodule

//--- testbench/aud_recorder_assert.sv
`timescale 1ns/10ps

module aud_recorder_assert (
    input logic           i_clk,
    input logic           i_rst_n,
    input logic           i_wr,
    input logic           i_finish,
    input aud_pkg::addr_t i_address
);
    import aud_pkg::*;

    addr_t last_addr;
    logic  have_last;
    logic  fin_seen;  // Restart after finish may go back to 0
    int    fail_cnt = 0;  // Failed assertions

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            last_addr <= '0;
            have_last <= 1'b0;
            fin_seen  <= 1'b0;
        end else begin
            if (i_wr) begin
                last_addr <= i_address;
                have_last <= 1'b1;
            end
            if (i_finish) begin
                fin_seen <= 1'b1;
            end else if (i_wr && i_address == '0) begin
                fin_seen <= 1'b0;
            end
        end
    end

    a_wr_single: assert property (@(posedge i_clk) disable iff (i_rst_n) i_wr |=> !i_wr)
        else begin
            $error("o_wr high in two consecutive cycles");
            fail_cnt++;
        end

    a_finish_single: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_finish |=> !i_finish)
        else begin
            $error("o_finish longer than one cycle");
            fail_cnt++;
        end

    a_addr_step: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (i_wr && have_last) |-> (i_address == last_addr + 1'b1) || (fin_seen && i_address == '0))
        else begin
            $error("o_address did not advance by one between writes");
            fail_cnt++;
        end

endmodule

bind aud_recorder_top aud_recorder_assert i_aud_recorder_assert (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_wr      (o_wr),
    .i_finish  (o_finish),
    .i_address (o_address)
);

//--- testbench/aud_checker.sv
`timescale 1ns/10ps

module aud_checker (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_lrc,
    input  logic             i_data,
    input  logic             i_start,
    input  logic             i_pause,
    input  logic             i_stop,
    input  aud_pkg::addr_t   i_address,
    input  aud_pkg::sample_t i_wr_data,
    input  logic             i_wr,
    input  logic             i_recording,
    input  logic             i_finish,
    output int               o_errors,
    output int               o_writes
);
    import aud_pkg::*;

    xport_state_t st;
    logic         model_ok = 1'b0;
    logic         lrc_d;
    logic         cap_act;
    int           cap_cnt;
    logic         cap_bits [SAMPLE_BITS];
    addr_t        next_addr;
    int           cyc = 0;
    int           err_cnt = 0;
    int           wr_cnt = 0;
    addr_t        exp_addr_q[$];
    sample_t      exp_data_q[$];
    int           exp_cyc_q[$];

    assign o_errors = err_cnt;
    assign o_writes = wr_cnt;

    // First bit received is the MSB
    function automatic sample_t slot_value(input logic bits [SAMPLE_BITS]);
        sample_t v;
        for (int i = 0; i < SAMPLE_BITS; i++) begin
            v[SAMPLE_BITS-1-i] = bits[i];
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
        err_cnt++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    // Outputs and inputs are both settled at the falling edge
    always @(negedge i_clk) begin
        logic lrc_fall;
        logic rec_en;
        cyc++;
        if (model_ok) begin
            if (i_recording !== (st == REC))
                report_mismatch("o_recording", i_recording, st == REC);
            if (i_finish !== (st == FINISH))
                report_mismatch("o_finish", i_finish, st == FINISH);
            if (i_wr === 1'b1) begin
                if (exp_addr_q.size() == 0) begin
                    report_problem("memory write with no sample expected");
                end else begin
                    if (cyc != exp_cyc_q[0])
                        report_problem("memory write came at the wrong cycle");
                    if (i_address !== exp_addr_q[0])
                        report_mismatch("o_address", i_address, exp_addr_q[0]);
                    if (i_wr_data !== exp_data_q[0])
                        report_mismatch("o_data", i_wr_data, exp_data_q[0]);
                    void'(exp_addr_q.pop_front());
                    void'(exp_data_q.pop_front());
                    void'(exp_cyc_q.pop_front());
                    wr_cnt++;
                end
            end else if (i_wr !== 1'b0) begin
                report_problem("o_wr is unknown");
            end else if (exp_cyc_q.size() != 0 && cyc >= exp_cyc_q[0]) begin
                report_problem("expected memory write did not appear");
                void'(exp_addr_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_cyc_q.pop_front());
            end
        end
        if (i_rst_n) begin
            st        = IDLE;
            lrc_d     = i_lrc;
            cap_act   = 1'b0;
            cap_cnt   = 0;
            next_addr = '0;
            exp_addr_q.delete();
            exp_data_q.delete();
            exp_cyc_q.delete();
            model_ok  = 1'b1;
        end else if (model_ok) begin
            lrc_fall = lrc_d & ~i_lrc;
            rec_en   = (st == REC) || (st == ARM && lrc_fall);
            if (i_lrc !== lrc_d) begin
                cap_act = rec_en;  // Delay bit on this edge
                cap_cnt = 0;
            end else if (cap_act) begin
                cap_bits[cap_cnt] = i_data;
                cap_cnt++;
                if (cap_cnt == SAMPLE_BITS) begin
                    exp_addr_q.push_back(next_addr);
                    exp_data_q.push_back(slot_value(cap_bits));
                    exp_cyc_q.push_back(cyc + 2);  // Deser strobe then writer
                    next_addr++;
                    cap_act = 1'b0;
                end
            end
            lrc_d = i_lrc;
            case (st)
                IDLE: begin
                    if (i_start) begin
                        st        = ARM;
                        next_addr = '0;
                    end
                end
                ARM: begin
                    if (lrc_fall) st = REC;
                end
                REC: begin
                    if (i_stop) st = FINISH;
                    else if (i_pause) st = PAUSE;
                end
                PAUSE: begin
                    if (i_stop) st = FINISH;
                    else if (i_pause) st = REC;
                end
                default: st = IDLE;
            endcase
        end
    end

endmodule

//--- testbench/tb_aud_recorder.sv
`timescale 1ns/10ps

module tb_aud_recorder;
    import aud_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int HALF_FRAME     = 20;
    localparam int NUM_FRAMES     = 24;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 2 * HALF_FRAME + 200;

    logic        clk;
    logic        rst_n;
    logic        lrc;
    logic        data;
    logic        start;
    logic        pause;
    logic        stop;
    addr_t       address;
    sample_t     wr_data;
    logic        wr;
    logic        recording;
    logic        finish;
    int          errors;
    int          writes;
    int          assert_fails;
    logic [31:0] lfsr = 32'h75bc;

    aud_recorder_top i_aud_recorder_top (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_lrc       (lrc),
        .i_data      (data),
        .i_start     (start),
        .i_pause     (pause),
        .i_stop      (stop),
        .o_address   (address),
        .o_data      (wr_data),
        .o_wr        (wr),
        .o_recording (recording),
        .o_finish    (finish)
    );

    aud_checker i_aud_checker (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_lrc       (lrc),
        .i_data      (data),
        .i_start     (start),
        .i_pause     (pause),
        .i_stop      (stop),
        .i_address   (address),
        .i_wr_data   (wr_data),
        .i_wr        (wr),
        .i_recording (recording),
        .i_finish    (finish),
        .o_errors    (errors),
        .o_writes    (writes)
    );

    assign assert_fails = i_aud_recorder_top.i_aud_recorder_assert.fail_cnt;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic pulse_strobes(input logic s, input logic p, input logic t);
        @(posedge clk);
        #1;
        start = s;
        pause = p;
        stop  = t;
        @(posedge clk);
        #1;
        start = 1'b0;
        pause = 1'b0;
        stop  = 1'b0;
    endtask

    task automatic print_counts();
        $display("Errors: %0d, assertion failures: %0d, writes checked: %0d",
                 errors, assert_fails, writes);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // I2S source, lrc toggles every half frame, bits on edges 2 to 17
    initial begin
        int phase;
        lrc   = 1'b1;  // First falling edge is a clean frame start
        data  = 1'b0;
        phase = 1;
        forever begin
            @(posedge clk);
            #1;
            if (phase == 0) lrc = ~lrc;
            if (phase >= 1 && phase <= SAMPLE_BITS) begin
                data = lfsr[31];
                lfsr = lfsr_step(lfsr);
            end else begin
                data = 1'b0;
            end
            phase = (phase + 1) % HALF_FRAME;
        end
    end

    initial begin
        rst_n = 1'b1;
        start = 1'b0;
        pause = 1'b0;
        stop  = 1'b0;
        wait_cycles(RESET_CYCLES);
        #1 rst_n = 1'b0;
        wait_cycles(50);              // Idle, nothing may be written
        @(negedge lrc);
        wait_cycles(5);
        pulse_strobes(1'b1, 1'b0, 1'b0);  // Start mid left slot
        wait_cycles(160);
        @(posedge lrc);
        wait_cycles(6);
        pulse_strobes(1'b0, 1'b1, 1'b0);  // Pause mid right slot
        wait_cycles(90);
        pulse_strobes(1'b0, 1'b1, 1'b0);  // Resume
        wait_cycles(100);
        @(negedge lrc);
        wait_cycles(10);
        pulse_strobes(1'b0, 1'b0, 1'b1);  // Stop mid left slot
        wait_cycles(50);
        pulse_strobes(1'b1, 1'b0, 1'b0);  // Restart from address 0
        wait_cycles(130);
        pulse_strobes(1'b0, 1'b0, 1'b1);
        wait_cycles(60);
        if (writes == 0) $display("No memory writes were seen");
        print_counts();
        if (errors == 0 && assert_fails == 0 && writes > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait_cycles(TIMEOUT_CYCLES);
        $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
        print_counts();
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- src.f
verilog/aud_pkg.sv
verilog/aud_transport.sv
verilog/aud_slot_deser.sv
verilog/aud_mem_writer.sv
verilog/aud_recorder_top.sv
testbench/aud_recorder_assert.sv
testbench/aud_checker.sv
testbench/tb_aud_recorder.sv
